// ==== bench/aes_core_checker.sv ====
`timescale 1ns/1ps

module aes_core_checker
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       in_ready,
	input  logic       out_valid,
	input  aes_block_u out_data,
	input  logic       exp_push,
	input  logic [7:0] exp_test,
	input  logic       exp_last,
	input  aes_block_u exp_data,
	input  logic       stall_window,
	output int         errors,
	output int         checks,
	output int         pending
);

	// Expected blocks in issue order
	aes_block_u exp_q[$];
	logic [7:0] test_q[$];
	logic last_q[$];
	// Cycle numbers of the accepting edges
	int accept_q[$];
	int cycle = 0;
	int err_count = 0;
	int check_count = 0;
	int pending_n = 0;
	int test_blocks = 0;
	int test_errors = 0;
	logic reset_checked = 1'b0;
	logic stall_reported = 1'b0;

	assign errors = err_count;
	assign checks = check_count;
	assign pending = pending_n;

	task automatic count_error();
		err_count++;
		test_errors++;
	endtask

	// ================================================
	// Port monitor
	// ================================================

	always @(posedge clk)
	begin : watch
		aes_block_u expected;
		logic [7:0] test_num;
		logic last;
		int latency;
		cycle++;
		if (rst_n)
		begin
			// Idle state right after reset
			if (!reset_checked)
			begin
				reset_checked = 1'b1;
				if (in_ready !== 1'b1)
				begin
					$display("MISMATCH in_ready after reset expected %h actual %h", 1'b1, in_ready);
					count_error();
				end
				if (out_valid !== 1'b0)
				begin
					$display("MISMATCH out_valid after reset expected %h actual %h", 1'b0, out_valid);
					count_error();
				end
			end
			if (exp_push)
			begin
				exp_q.push_back(exp_data);
				test_q.push_back(exp_test);
				last_q.push_back(exp_last);
			end
			if (in_valid && in_ready)
				accept_q.push_back(cycle);
			if (out_valid && exp_q.size() == 0)
			begin
				$display("out_valid pulsed with no block outstanding");
				count_error();
			end
			else if (out_valid)
			begin
				expected = exp_q.pop_front();
				test_num = test_q.pop_front();
				last = last_q.pop_front();
				check_count++;
				test_blocks++;
				if (out_data !== expected)
				begin
					$display("MISMATCH out_data test %0d expected %h actual %h",
						test_num, expected, out_data);
					count_error();
				end
				// Fixed distance from accept to out_valid
				if (accept_q.size() > 0)
				begin
					latency = cycle - accept_q.pop_front();
					if (latency != CORE_LATENCY)
					begin
						$display("test %0d block came %0d cycles after its accept, not %0d",
							test_num, latency, CORE_LATENCY);
						count_error();
					end
				end
				if (last)
				begin
					$display("test %0d finished: %0d blocks, %0d errors",
						test_num, test_blocks, test_errors);
					test_blocks = 0;
					test_errors = 0;
				end
			end
			// Sink holds its credits, nothing may start or finish
			if (!stall_window)
				stall_reported = 1'b0;
			else if ((in_ready || out_valid) && !stall_reported)
			begin
				$display("in_ready or out_valid went high with no output credit left");
				stall_reported = 1'b1;
				count_error();
			end
		end
		pending_n = exp_q.size();
	end

endmodule

// ==== bench/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb
	import aes_pkg::*;
();

	// ================================================
	// Vectors from FIPS-197 and SP800-38A
	// ================================================

	localparam logic [127:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] PT_C1 = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] CT_C1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] KEY_SP = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] PT_B = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [127:0] CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam logic [127:0] IV_CTR = 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff;
	localparam logic [127:0] PT1 = 128'h6bc1bee22e409f96e93d7e117393172a;
	localparam logic [127:0] PT2 = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
	localparam logic [127:0] PT3 = 128'h30c81c46a35ce411e5fbc1191a0a52ef;
	localparam logic [127:0] PT4 = 128'hf69f2445df4f9b17ad2b417be66c3710;
	localparam logic [127:0] ECB1 = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
	localparam logic [127:0] ECB2 = 128'hf5d3d58503b9699de785895a96fdbaaf;
	localparam logic [127:0] ECB3 = 128'h43b1cd7f598ece23881b00e3ed030688;
	localparam logic [127:0] ECB4 = 128'h7b0c785e27e8ad3f8223207104725dd4;
	localparam logic [127:0] CTR1 = 128'h874d6191b620e3261bef6864990db6ce;
	localparam logic [127:0] CTR2 = 128'h9806f66b7970fdff8617187bb9fffdff;
	localparam logic [127:0] CTR3 = 128'h5ae4df3edbd5d35e5b4f09020db03eab;
	localparam logic [127:0] CTR4 = 128'h1e031dda2fbe03d1792170a0f3009cee;

	// Wait limits in clock cycles
	localparam int READY_TIMEOUT = 4 * CORE_LATENCY;
	localparam int DRAIN_TIMEOUT = 4 * CORE_LATENCY;
	localparam int STALL_CYCLES = 2 * CORE_LATENCY;

	// One table row per block
	typedef struct packed {
		logic [7:0] test;
		aes_block_u key;
		aes_block_u iv;
		logic mode_ctr;
		logic hold;
		logic stall;
		aes_block_u data;
		aes_block_u expected;
	} vector_t;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	aes_req_t in_req;
	logic key_load;
	aes_block_u key;
	logic iv_load;
	aes_block_u iv;
	logic out_valid;
	aes_block_u out_data;
	logic credit_return;
	logic exp_push;
	logic [7:0] exp_test;
	logic exp_last;
	aes_block_u exp_data;
	logic stall_window;
	int errors;
	int checks;
	int pending;

	vector_t vectors[$];
	logic [31:0] lcg_state;
	int owed = 0;
	int gap = 0;
	logic hold_credits = 1'b0;
	logic timed_out;
	aes_block_u cur_key;
	aes_block_u cur_iv;
	logic key_known;
	logic iv_known;

	always #5 clk = ~clk;

	aes_core dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_req        (in_req),
		.key_load      (key_load),
		.key           (key),
		.iv_load       (iv_load),
		.iv            (iv),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.credit_return (credit_return)
	);

	aes_core_checker checker_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.exp_push     (exp_push),
		.exp_test     (exp_test),
		.exp_last     (exp_last),
		.exp_data     (exp_data),
		.stall_window (stall_window),
		.errors       (errors),
		.checks       (checks),
		.pending      (pending)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Top bits only, 0 to 15 cycles
	function automatic int credit_gap();
		return int'(lcg_next() >> 28);
	endfunction

	// ================================================
	// Credit returns from the sink
	// ================================================

	always @(negedge clk)
	begin
		credit_return = 1'b0;
		if (out_valid === 1'b1)
			owed++;
		if (owed > 0 && !hold_credits)
		begin
			if (gap == 0)
			begin
				credit_return = 1'b1;
				owed--;
				gap = credit_gap();
			end
			else
				gap--;
		end
	end

	// ================================================
	// Stimulus table
	// ================================================

	task automatic add_row(
		input logic [7:0] test,
		input logic [127:0] key_v,
		input logic [127:0] iv_v,
		input logic mode,
		input logic hold,
		input logic stall,
		input logic [127:0] data,
		input logic [127:0] expected
	);
		vector_t r;
		r.test = test;
		r.key = key_v;
		r.iv = iv_v;
		r.mode_ctr = mode;
		r.hold = hold;
		r.stall = stall;
		r.data = data;
		r.expected = expected;
		vectors.push_back(r);
	endtask

	task automatic build_table();
		// Single ECB block after reset
		add_row(8'd1, KEY_C1, '0, 1'b0, 1'b0, 1'b0, PT_C1, CT_C1);
		// ECB under one key
		add_row(8'd2, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT1, ECB1);
		add_row(8'd2, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT2, ECB2);
		add_row(8'd2, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT3, ECB3);
		add_row(8'd2, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT4, ECB4);
		// CTR, counter loaded once
		add_row(8'd3, KEY_SP, IV_CTR, 1'b1, 1'b0, 1'b0, PT1, CTR1);
		add_row(8'd3, KEY_SP, IV_CTR, 1'b1, 1'b0, 1'b0, PT2, CTR2);
		add_row(8'd3, KEY_SP, IV_CTR, 1'b1, 1'b0, 1'b0, PT3, CTR3);
		add_row(8'd3, KEY_SP, IV_CTR, 1'b1, 1'b0, 1'b0, PT4, CTR4);
		// Credits held, third block stalls
		add_row(8'd4, KEY_SP, '0, 1'b0, 1'b1, 1'b0, PT1, ECB1);
		add_row(8'd4, KEY_SP, '0, 1'b0, 1'b1, 1'b0, PT2, ECB2);
		add_row(8'd4, KEY_SP, '0, 1'b0, 1'b1, 1'b1, PT3, ECB3);
		add_row(8'd4, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT4, ECB4);
		// Key swapped between blocks
		add_row(8'd5, KEY_C1, '0, 1'b0, 1'b0, 1'b0, PT_C1, CT_C1);
		add_row(8'd5, KEY_SP, '0, 1'b0, 1'b0, 1'b0, PT_B, CT_B);
	endtask

	// ================================================
	// Driver
	// ================================================

	task automatic wait_ready(input logic [7:0] test);
		int n;
		n = 0;
		while (!timed_out && !in_ready && n < READY_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!timed_out && !in_ready)
		begin
			timed_out = 1'b1;
			$display("TIMEOUT in test %0d, in_ready stayed low for %0d cycles", test, n);
		end
	endtask

	// Outstanding blocks, and credits too when asked
	task automatic drain_outputs(input logic with_credits);
		int n;
		n = 0;
		while (!timed_out && (pending != 0 || (with_credits && owed != 0)) &&
			n < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= DRAIN_TIMEOUT)
		begin
			timed_out = 1'b1;
			$display("TIMEOUT with %0d blocks and %0d credits still outstanding", pending, owed);
		end
	endtask

	task automatic apply_row(input int i);
		vector_t row;
		logic last;
		row = vectors[i];
		last = (i == vectors.size() - 1) || (vectors[i+1].test != row.test);
		hold_credits = row.hold;
		in_req.block = row.data;
		in_req.mode_ctr = row.mode_ctr;
		if (row.stall)
		begin
			// Credited blocks finish first, then the request waits with no credit
			drain_outputs(1'b0);
			in_valid = 1'b1;
			stall_window = 1'b1;
			repeat (STALL_CYCLES) @(negedge clk);
			stall_window = 1'b0;
			hold_credits = 1'b0;
		end
		wait_ready(row.test);
		if (!timed_out)
		begin
			// Accepted on the next rising edge
			in_valid = 1'b1;
			key_load = !key_known || (row.key != cur_key);
			key = row.key;
			iv_load = row.mode_ctr && (!iv_known || (row.iv != cur_iv));
			iv = row.iv;
			cur_key = row.key;
			key_known = 1'b1;
			if (iv_load)
			begin
				cur_iv = row.iv;
				iv_known = 1'b1;
			end
			exp_push = 1'b1;
			exp_test = row.test;
			exp_last = last;
			exp_data = row.expected;
			@(negedge clk);
			in_valid = 1'b0;
			key_load = 1'b0;
			iv_load = 1'b0;
			exp_push = 1'b0;
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_req = '0;
		key_load = 1'b0;
		key = '0;
		iv_load = 1'b0;
		iv = '0;
		credit_return = 1'b0;
		exp_push = 1'b0;
		exp_test = '0;
		exp_last = 1'b0;
		exp_data = '0;
		stall_window = 1'b0;
		lcg_state = 32'h11ed_cf7c;
		gap = credit_gap();
		timed_out = 1'b0;
		key_known = 1'b0;
		iv_known = 1'b0;
		cur_key = '0;
		cur_iv = '0;
		build_table();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < vectors.size() && !timed_out; i++)
		begin
			// Each test starts with all credits back
			if (i > 0 && vectors[i].test != vectors[i-1].test)
				drain_outputs(1'b1);
			if (!timed_out)
				apply_row(i);
		end
		if (!timed_out)
			drain_outputs(1'b1);
		$display("%0d of %0d blocks checked, %0d errors", checks, vectors.size(), errors);
		if (!timed_out && errors == 0 && checks == vectors.size() && pending == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== design/aes_control.sv ====
`timescale 1ns/1ps

module aes_control
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  logic      mode_ctr,
	input  logic      credit_return,
	output logic      in_ready,
	output logic      out_valid,
	output aes_ctrl_t ctrl
);

	typedef enum logic [3:0] {
		IDLE,
		R0_COL0,
		R0_COL1,
		R0_COL2,
		R0_COL3,
		ROUND_KEY,
		ROUND_COL0,
		ROUND_COL1,
		ROUND_COL2,
		ROUND_COL3,
		DONE
	} state_e;

	state_e state;
	state_e next_state;
	logic [3:0] round_q;
	logic [CREDIT_W-1:0] credits;
	logic mode_q;
	logic accept;
	logic last_round;
	logic [1:0] col_idx;

	// Start only with a free output slot
	assign in_ready = (state == IDLE) && (credits != '0);
	assign accept = in_valid && in_ready;
	assign out_valid = (state == DONE);
	assign last_round = (round_q == 4'(NUM_ROUNDS));

	// ================================================
	// Sequencer
	// ================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			round_q <= '0;
			mode_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (accept)
				mode_q <= mode_ctr;
			// Round number steps on the way into each key state
			if (state == IDLE)
				round_q <= '0;
			else if (state == R0_COL3 || (state == ROUND_COL3 && !last_round))
				round_q <= round_q + 1'b1;
		end
	end

	// No stall once a block is running
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (accept)
					next_state = R0_COL0;
			end
			R0_COL0:    next_state = R0_COL1;
			R0_COL1:    next_state = R0_COL2;
			R0_COL2:    next_state = R0_COL3;
			R0_COL3:    next_state = ROUND_KEY;
			ROUND_KEY:  next_state = ROUND_COL0;
			ROUND_COL0: next_state = ROUND_COL1;
			ROUND_COL1: next_state = ROUND_COL2;
			ROUND_COL2: next_state = ROUND_COL3;
			ROUND_COL3: next_state = last_round ? DONE : ROUND_KEY;
			default:    next_state = IDLE;
		endcase
	end

	// Active column of the column states
	always_comb
	begin
		case (state)
			R0_COL1, ROUND_COL1: col_idx = 2'd1;
			R0_COL2, ROUND_COL2: col_idx = 2'd2;
			R0_COL3, ROUND_COL3: col_idx = 2'd3;
			default:             col_idx = 2'd0;
		endcase
	end

	// ================================================
	// Control word
	// ================================================

	always_comb
	begin
		ctrl = '0;
		ctrl.sbox_sel = COL_0;
		ctrl.col_sel = INPUT;
		ctrl.round = round_q;
		case (state)
			// Block lands in the state on the accepting edge
			IDLE:
				ctrl.load_block = accept;
			// Round zero key add on the raw columns
			R0_COL0, R0_COL1, R0_COL2, R0_COL3:
			begin
				ctrl.sbox_sel = sbox_sel_e'({1'b0, col_idx});
				ctrl.col_en = 4'b0001 << col_idx;
			end
			// S-box goes to the g-function, whole state gets ShiftRows
			ROUND_KEY:
			begin
				ctrl.sbox_sel = G_FUNCTION;
				ctrl.col_sel = SHIFT_ROWS;
				ctrl.col_en = 4'b1111;
				ctrl.key_en = 4'b0001;
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				ctrl.sbox_sel = sbox_sel_e'({1'b0, col_idx});
				ctrl.col_sel = ADD_RK_OUT;
				ctrl.col_en = 4'b0001 << col_idx;
				// Next key word one column ahead, none after column 3
				ctrl.key_en = 4'b0010 << col_idx;
				ctrl.mix_bypass = last_round;
				ctrl.ctr_xor = mode_q && last_round;
				ctrl.ctr_step = mode_q && last_round && (col_idx == 2'd3);
			end
			default:
				ctrl.load_block = 1'b0;
		endcase
	end

	// ================================================
	// Output credits
	// ================================================

	// Simultaneous out_valid and return cancel out
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= CREDIT_W'(OUT_CREDITS);
		else if (out_valid && !credit_return)
			credits <= credits - 1'b1;
		else if (credit_return && !out_valid)
			credits <= credits + 1'b1;
	end

	// Every accepted block reaches out_valid after the fixed latency
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> ##CORE_LATENCY out_valid);

	// Slot reserved at start is still there at the end
	a_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (credits != '0));

	// Single column writes apart from ShiftRows
	a_col_en: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ctrl.col_en) || (ctrl.col_sel == SHIFT_ROWS));

endmodule

// ==== design/aes_core.sv ====
`timescale 1ns/1ps

module aes_core
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	output logic       in_ready,
	input  aes_req_t   in_req,
	input  logic       key_load,
	input  aes_block_u key,
	input  logic       iv_load,
	input  aes_block_u iv,
	output logic       out_valid,
	output aes_block_u out_data,
	input  logic       credit_return
);

	aes_ctrl_t ctrl;
	aes_word_t sbox_in;
	aes_word_t sub_word;
	aes_word_t rot_word;
	aes_word_t rk_word;

	// ================================================
	// Sequencer
	// ================================================

	aes_control control_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.mode_ctr      (in_req.mode_ctr),
		.credit_return (credit_return),
		.in_ready      (in_ready),
		.out_valid     (out_valid),
		.ctrl          (ctrl)
	);

	// ================================================
	// Datapath, key schedule and shared S-box
	// ================================================

	aes_datapath datapath_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.iv_load  (iv_load),
		.iv       (iv),
		.ctrl     (ctrl),
		.rot_word (rot_word),
		.rk_word  (rk_word),
		.sub_word (sub_word),
		.sbox_in  (sbox_in),
		.out_data (out_data)
	);

	aes_key_sched key_sched_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.key_load (key_load),
		.key      (key),
		.ctrl     (ctrl),
		.sub_word (sub_word),
		.rot_word (rot_word),
		.rk_word  (rk_word)
	);

	// Output fans out to columns and g-function
	aes_sbox sbox_i (
		.in_word  (sbox_in),
		.out_word (sub_word)
	);

endmodule

// ==== design/aes_datapath.sv ====
`timescale 1ns/1ps

module aes_datapath
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  aes_req_t   in_req,
	input  logic       iv_load,
	input  aes_block_u iv,
	input  aes_ctrl_t  ctrl,
	input  aes_word_t  rot_word,
	input  aes_word_t  rk_word,
	input  aes_word_t  sub_word,
	output aes_word_t  sbox_in,
	output aes_block_u out_data
);

	aes_block_u state_q;
	aes_block_u data_q;
	aes_block_u ctr_q;
	aes_block_u ctr_now;
	aes_block_u shifted;
	aes_word_t mixed;
	aes_word_t col_new;
	logic [1:0] col_idx;

	// Multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Rows rotate through the 2 3 1 1 pattern
	function automatic aes_word_t mix_column(input aes_word_t c);
		logic [0:3][7:0] a;
		logic [0:3][7:0] m;
		a = c;
		for (int r = 0; r < 4; r++)
			m[r] = xtime(a[r]) ^ xtime(a[(r+1)%4]) ^ a[(r+1)%4] ^ a[(r+2)%4] ^ a[(r+3)%4];
		return m;
	endfunction

	assign col_idx = ctrl.sbox_sel[1:0];
	assign out_data = state_q;
	assign ctr_now = iv_load ? iv : ctr_q;

	// ================================================
	// Column path
	// ================================================

	// Key schedule borrows the S-box in its g-function cycle
	assign sbox_in = (ctrl.sbox_sel == G_FUNCTION) ? rot_word : state_q.cols[col_idx];
	assign mixed = ctrl.mix_bypass ? sub_word : mix_column(sub_word);

	always_comb
	begin
		if (ctrl.col_sel == INPUT)
			col_new = state_q.cols[col_idx] ^ rk_word;
		else
			col_new = mixed ^ rk_word ^ (ctrl.ctr_xor ? data_q.cols[col_idx] : '0);
	end

	// Row r moves left by r columns
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
				shifted.bytes[4*c + r] = state_q.bytes[4*((c + r) % 4) + r];
		end
	end

	// ================================================
	// State and saved block
	// ================================================

	always_ff @(posedge clk)
	begin
		if (ctrl.load_block)
		begin
			// CTR encrypts the counter, the data waits for the last round
			state_q <= in_req.mode_ctr ? ctr_now : in_req.block;
			data_q <= in_req.block;
		end
		else
		begin
			for (int c = 0; c < 4; c++)
			begin
				if (ctrl.col_en[c])
					state_q.cols[c] <= (ctrl.col_sel == SHIFT_ROWS) ? shifted.cols[c] : col_new;
			end
		end
	end

	// Counter steps once per CTR block
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ctr_q <= '0;
		else if (iv_load)
			ctr_q <= iv;
		else if (ctrl.ctr_step)
			ctr_q <= ctr_q + 1'b1;
	end

endmodule

// ==== design/aes_key_sched.sv ====
`timescale 1ns/1ps

module aes_key_sched
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       key_load,
	input  aes_block_u key,
	input  aes_ctrl_t  ctrl,
	input  aes_word_t  sub_word,
	output aes_word_t  rot_word,
	output aes_word_t  rk_word
);

	aes_block_u master_key;
	aes_block_u work;
	logic [7:0] rcon;
	logic busy;

	// Round constant for the round in its key state
	always_comb
	begin
		case (ctrl.round)
			4'd1:    rcon = 8'h01;
			4'd2:    rcon = 8'h02;
			4'd3:    rcon = 8'h04;
			4'd4:    rcon = 8'h08;
			4'd5:    rcon = 8'h10;
			4'd6:    rcon = 8'h20;
			4'd7:    rcon = 8'h40;
			4'd8:    rcon = 8'h80;
			4'd9:    rcon = 8'h1b;
			4'd10:   rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	end

	// RotWord of the previous key's last word, toward the S-box
	assign rot_word = {work.cols[3][23:0], work.cols[3][31:24]};
	// Word matching the column being written
	assign rk_word = work.cols[ctrl.sbox_sel[1:0]];

	always_ff @(posedge clk)
	begin
		if (key_load)
			master_key <= key;
	end

	// ================================================
	// On-the-fly expansion
	// ================================================

	always_ff @(posedge clk)
	begin
		// Key given with the block wins over the stored one
		if (ctrl.load_block)
			work <= key_load ? key : master_key;
		else
		begin
			if (ctrl.key_en[0])
				work.cols[0] <= work.cols[0] ^ sub_word ^ {rcon, 24'h000000};
			// Each word chains on the one written a cycle earlier
			for (int i = 1; i < 4; i++)
			begin
				if (ctrl.key_en[i])
					work.cols[i] <= work.cols[i] ^ work.cols[i-1];
			end
		end
	end

	// Block in flight from load to the last column write
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (ctrl.load_block)
			busy <= 1'b1;
		else if (ctrl.mix_bypass && ctrl.col_en[3])
			busy <= 1'b0;
	end

	// Host keeps its key steady while a block runs
	a_key_idle: assert property (@(posedge clk) disable iff (!rst_n)
		key_load |-> !busy);

endmodule

// ==== design/aes_pkg.sv ====
package aes_pkg;

	// ================================================
	// Core sizing
	// ================================================

	// AES-128 round count
	localparam int NUM_ROUNDS = 10;
	// Output slots granted by the sink after reset
	localparam int OUT_CREDITS = 2;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);
	// Accepting edge to the edge that samples out_valid
	localparam int CORE_LATENCY = 55;

	// ================================================
	// Data types
	// ================================================

	// One column or one key word, row 0 in the top byte
	typedef logic [31:0] aes_word_t;

	// Byte view for ShiftRows, column view for the column work
	// Byte 0 is the first block byte and sits in the top bits
	typedef union packed {
		logic [0:15][7:0] bytes;
		aes_word_t [0:3] cols;
	} aes_block_u;

	// Shared S-box user, low two bits double as the column index
	typedef enum logic [2:0] {
		COL_0,
		COL_1,
		COL_2,
		COL_3,
		G_FUNCTION
	} sbox_sel_e;

	// Source of the state write
	typedef enum logic [1:0] {
		SHIFT_ROWS,
		ADD_RK_OUT,
		INPUT
	} col_sel_e;

	// Sequencer to datapath and key schedule
	typedef struct packed {
		sbox_sel_e sbox_sel;
		col_sel_e col_sel;
		logic [3:0] col_en;
		logic [3:0] key_en;
		logic load_block;
		logic mix_bypass;
		logic ctr_xor;
		logic ctr_step;
		logic [3:0] round;
	} aes_ctrl_t;

	// Host request
	typedef struct packed {
		aes_block_u block;
		logic mode_ctr;
	} aes_req_t;

endpackage

// ==== design/aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox
	import aes_pkg::*;
(
	input  aes_word_t in_word,
	output aes_word_t out_word
);

	// ================================================
	// Forward S-box table
	// ================================================

	// Entry 0 lands in the top byte of the concatenation
	logic [0:255][7:0] sbox_tbl;

	// One row per high nibble of the input byte
	assign sbox_tbl = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// ================================================
	// Four lookups in parallel
	// ================================================

	// Same table for every byte lane
	for (genvar i = 0; i < 4; i++)
	begin : g_lane
		assign out_word[8*i +: 8] = sbox_tbl[in_word[8*i +: 8]];
	end

endmodule

// ==== project.f ====
design/aes_pkg.sv
design/aes_sbox.sv
design/aes_control.sv
design/aes_key_sched.sv
design/aes_datapath.sv
design/aes_core.sv
bench/aes_core_checker.sv
bench/aes_core_tb.sv
